//--- src/cyc_pkg.sv
// Default geometry for the cyclic weight buffer.
// W_DATA_WIDTH must be a whole multiple of R_DATA_WIDTH, and
// R_DEPTH a whole multiple of the resulting word ratio.

package cyc_pkg;

  // Number of narrow read words.
  localparam int DEF_R_DEPTH      = 16;

  // Width of one narrow read word.
  localparam int DEF_R_DATA_WIDTH = 8;

  // Width of one wide write word.
  localparam int DEF_W_DATA_WIDTH = 32;

  // RAM read latency in enabled cycles.
  localparam int DEF_LATENCY      = 3;

  // Number of read words packed into one write word.
  function automatic int word_ratio(input int r_width, input int w_width);
    return w_width / r_width;
  endfunction

endpackage

//--- src/ram_port_if.sv
// Port bundle of the asymmetric RAM.
// One write side with wide words, one read side with narrow words.

`timescale 1ns/1ns

interface ram_port_if import cyc_pkg::*; #(
  parameter int R_DEPTH      = DEF_R_DEPTH,
  parameter int R_DATA_WIDTH = DEF_R_DATA_WIDTH,
  parameter int W_DATA_WIDTH = DEF_W_DATA_WIDTH
);

  localparam int RATIO        = word_ratio(R_DATA_WIDTH, W_DATA_WIDTH);
  localparam int W_DEPTH      = R_DEPTH / RATIO;
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH);
  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH);

  logic                    en;     // Global enable, a copy of clken.
  logic                    we;     // Write strobe.
  logic [W_ADDR_WIDTH-1:0] waddr;  // Wide word address.
  logic [W_DATA_WIDTH-1:0] wdata;
  logic [R_ADDR_WIDTH-1:0] raddr;  // Narrow word address.
  logic [R_DATA_WIDTH-1:0] rdata;  // Valid LATENCY enabled cycles after raddr.

  modport ctrl (output en, we, waddr, wdata, raddr, input rdata);

  modport mem (input en, we, waddr, wdata, raddr, output rdata);

endinterface

//--- src/n_delay.sv
// Delay line of N register stages, moving only while clken is high.
// N of zero gives a plain wire. The payload type must be packed.

`timescale 1ns/1ns

module n_delay #(
  parameter int  N = 1,
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clken,
  input  T     data_in,
  output T     data_out
);

  if (N == 0) begin : g_wire
    assign data_out = data_in;
  end else begin : g_chain
    T stages [N];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        for (int i = 0; i < N; i++) begin
          stages[i] <= '0;
        end
      end else if (clken) begin
        stages[0] <= data_in;
        for (int i = 1; i < N; i++) begin
          stages[i] <= stages[i-1];  // Shift by one stage.
        end
      end
    end

    assign data_out = stages[N-1];
  end

endmodule

//--- src/sdp_ram.sv
// Behavioural simple dual-port RAM, wide write and narrow read.
// Read slice k of wide address a lives at a*RATIO+k, slice 0 in the low bits.
// LATENCY must be at least 1. A read of an address written on the same
// edge returns the old word. Contents are not cleared by reset.

`timescale 1ns/1ns

module sdp_ram import cyc_pkg::*; #(
  parameter int R_DEPTH      = DEF_R_DEPTH,
  parameter int R_DATA_WIDTH = DEF_R_DATA_WIDTH,
  parameter int W_DATA_WIDTH = DEF_W_DATA_WIDTH,
  parameter int LATENCY      = DEF_LATENCY
) (
  input  logic      clk,
  input  logic      rst_n,
  ram_port_if.mem   ram
);

  localparam int RATIO        = word_ratio(R_DATA_WIDTH, W_DATA_WIDTH);
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH);

  typedef logic [R_DATA_WIDTH-1:0] word_t;

  word_t mem [R_DEPTH];
  word_t rd_q;

  // All slices of one wide word land in the same cycle.
  always_ff @(posedge clk) begin
    if (ram.en && ram.we) begin
      for (int k = 0; k < RATIO; k++) begin
        mem[R_ADDR_WIDTH'(ram.waddr * RATIO + k)] <= ram.wdata[k*R_DATA_WIDTH +: R_DATA_WIDTH];
      end
    end
  end

  // First read stage; the output register of the array.
  always_ff @(posedge clk) begin
    if (ram.en) begin
      rd_q <= mem[ram.raddr];
    end
  end

  // Remaining stages stall together with the rest of the block.
  n_delay #(
    .N (LATENCY - 1),
    .T (word_t)
  ) u_rd_dly (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (ram.en),
    .data_in  (rd_q),
    .data_out (ram.rdata)
  );

endmodule

//--- src/sync_fifo.sv
// Small synchronous FIFO for read words already in flight.
// There is no full flag: the caller must size DEPTH so it cannot overflow.
// dout and valid follow a pop by one cycle and hold while clken is low.

`timescale 1ns/1ns

module sync_fifo #(
  parameter int DEPTH      = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clken,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  valid,
  output logic                  empty
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] buf_q [DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;
  logic                  do_push;
  logic                  do_pop;

  assign empty   = (count == '0);
  assign do_push = clken && push;
  assign do_pop  = clken && pop && !empty;  // Pop on empty is ignored.

  always_ff @(posedge clk) begin
    if (do_push) begin
      buf_q[wr_ptr] <= din;
    end
    if (do_pop) begin
      dout <= buf_q[rd_ptr];  // Head word goes out on the next cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else if (clken) begin
      valid <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone.
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/cyclic_bram.sv
// Address generators and output path of the cyclic weight buffer.
// Writes wrap from w_addr_max to 0, reads from r_addr_max to r_addr_min.
// m_valid holds its value while clken is low, so a word counts once per
// enabled cycle. With ABSORB set, r_en also acts as the pop strobe.

`timescale 1ns/1ns

module cyclic_bram import cyc_pkg::*; #(
  parameter int R_DEPTH      = DEF_R_DEPTH,
  parameter int R_DATA_WIDTH = DEF_R_DATA_WIDTH,
  parameter int W_DATA_WIDTH = DEF_W_DATA_WIDTH,
  parameter int LATENCY      = DEF_LATENCY,
  parameter bit ABSORB       = 1'b0,
  localparam int RATIO        = word_ratio(R_DATA_WIDTH, W_DATA_WIDTH),
  localparam int W_DEPTH      = R_DEPTH / RATIO,
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH),
  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clken,
  input  logic                    w_en,
  input  logic                    r_en,
  input  logic [W_DATA_WIDTH-1:0] s_data,
  input  logic [R_ADDR_WIDTH-1:0] r_addr_max,
  input  logic [R_ADDR_WIDTH-1:0] r_addr_min,
  input  logic [W_ADDR_WIDTH-1:0] w_addr_max,
  output logic [R_DATA_WIDTH-1:0] m_data,
  output logic                    m_valid,
  ram_port_if.ctrl                ram
);

  // Room for every word in flight plus the one left from a running stream.
  localparam int FIFO_DEPTH = 2 ** $clog2(LATENCY + 1);

  logic [W_ADDR_WIDTH-1:0] w_addr;
  logic [R_ADDR_WIDTH-1:0] r_addr;
  logic                    rd_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_addr <= '0;
    end else if (clken && w_en) begin
      w_addr <= (w_addr < w_addr_max) ? w_addr + 1'b1 : '0;
    end
  end

  // The first lap starts at 0; later laps start at r_addr_min.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_addr <= '0;
    end else if (clken && r_en) begin
      r_addr <= (r_addr < r_addr_max) ? r_addr + 1'b1 : r_addr_min;
    end
  end

  assign ram.en    = clken;
  assign ram.we    = w_en;
  assign ram.waddr = w_addr;
  assign ram.wdata = s_data;
  assign ram.raddr = r_addr;

  // Marks the RAM output words that belong to a real read.
  n_delay #(
    .N (LATENCY),
    .T (logic)
  ) u_valid_dly (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (clken),
    .data_in  (r_en),
    .data_out (rd_valid)
  );

  if (ABSORB) begin : g_absorb
    logic fifo_empty;
    logic fifo_pop;

    assign fifo_pop = r_en && !fifo_empty;  // Reader pauses by dropping r_en.

    sync_fifo #(
      .DEPTH      (FIFO_DEPTH),
      .DATA_WIDTH (R_DATA_WIDTH)
    ) u_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .clken (clken),
      .push  (rd_valid),
      .din   (ram.rdata),
      .pop   (fifo_pop),
      .dout  (m_data),
      .valid (m_valid),
      .empty (fifo_empty)
    );
  end else begin : g_direct
    assign m_data  = ram.rdata;
    assign m_valid = rd_valid;
  end

endmodule

//--- src/weight_buffer_top.sv
// Cyclic weight buffer: wide writes, narrow cyclic reads.
// W_DATA_WIDTH must be a multiple of R_DATA_WIDTH and LATENCY at least 1.

`timescale 1ns/1ns

module weight_buffer_top import cyc_pkg::*; #(
  parameter int R_DEPTH      = DEF_R_DEPTH,
  parameter int R_DATA_WIDTH = DEF_R_DATA_WIDTH,
  parameter int W_DATA_WIDTH = DEF_W_DATA_WIDTH,
  parameter int LATENCY      = DEF_LATENCY,
  parameter bit ABSORB       = 1'b0,
  localparam int RATIO        = word_ratio(R_DATA_WIDTH, W_DATA_WIDTH),
  localparam int W_DEPTH      = R_DEPTH / RATIO,
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH),
  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clken,
  input  logic                    w_en,
  input  logic                    r_en,
  input  logic [W_DATA_WIDTH-1:0] s_data,
  input  logic [R_ADDR_WIDTH-1:0] r_addr_max,
  input  logic [R_ADDR_WIDTH-1:0] r_addr_min,
  input  logic [W_ADDR_WIDTH-1:0] w_addr_max,
  output logic [R_DATA_WIDTH-1:0] m_data,
  output logic                    m_valid
);

  ram_port_if #(
    .R_DEPTH      (R_DEPTH),
    .R_DATA_WIDTH (R_DATA_WIDTH),
    .W_DATA_WIDTH (W_DATA_WIDTH)
  ) ram ();

  cyclic_bram #(
    .R_DEPTH      (R_DEPTH),
    .R_DATA_WIDTH (R_DATA_WIDTH),
    .W_DATA_WIDTH (W_DATA_WIDTH),
    .LATENCY      (LATENCY),
    .ABSORB       (ABSORB)
  ) u_cyclic_bram (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (s_data),
    .r_addr_max (r_addr_max),
    .r_addr_min (r_addr_min),
    .w_addr_max (w_addr_max),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .ram        (ram.ctrl)
  );

  sdp_ram #(
    .R_DEPTH      (R_DEPTH),
    .R_DATA_WIDTH (R_DATA_WIDTH),
    .W_DATA_WIDTH (W_DATA_WIDTH),
    .LATENCY      (LATENCY)
  ) u_sdp_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .ram   (ram.mem)
  );

endmodule

//--- testbench/tb_sva.sv
// Assertions bound into cyclic_bram.
// The FIFO occupancy is tracked here from the push and pop strobes, and
// DEPTH must match the FIFO depth inside cyclic_bram.

`timescale 1ns/1ns

module tb_sva #(
  parameter int R_AW  = 4,
  parameter int W_AW  = 2,
  parameter int DEPTH = 4
) (
  input logic            clk,
  input logic            rst_n,
  input logic            clken,
  input logic            r_en,
  input logic [R_AW-1:0] r_addr,
  input logic [R_AW-1:0] r_addr_max,
  input logic [W_AW-1:0] w_addr,
  input logic [W_AW-1:0] w_addr_max,
  input logic            push,
  input logic            m_valid
);

  int   occupancy;
  logic wrapped;  // Set once the read address has reached r_addr_max.
  logic do_push;
  logic do_pop;

  assign do_push = clken && push;
  assign do_pop  = clken && r_en && (occupancy != 0);

  always @(posedge clk) begin
    if (!rst_n) begin
      occupancy <= 0;
      wrapped   <= 1'b0;
    end else begin
      occupancy <= occupancy + (do_push ? 1 : 0) - (do_pop ? 1 : 0);
      if (clken && r_en && r_addr >= r_addr_max) begin
        wrapped <= 1'b1;
      end
    end
  end

  a_read_window : assert property (@(posedge clk) disable iff (!rst_n)
    wrapped |-> r_addr <= r_addr_max)
    else $error("read address beyond r_addr_max after wrap");

  a_write_window : assert property (@(posedge clk) disable iff (!rst_n)
    w_addr <= w_addr_max)
    else $error("write address beyond w_addr_max");

  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(do_push && !do_pop && occupancy >= DEPTH))
    else $error("push into a full FIFO");

  a_reset_valid : assert property (@(posedge clk) !rst_n |=> !m_valid)
    else $error("m_valid high after a reset edge");

endmodule

//--- testbench/tb_top.sv
// Testbench for weight_buffer_top with ABSORB set and default geometry.
// Expected words are queued at issue time and compared on each m_valid.
// Words left in flight after the last read are counted, not drained.

`timescale 1ns/1ns

module tb_top;
  import cyc_pkg::*;

  localparam int RATIO          = word_ratio(DEF_R_DATA_WIDTH, DEF_W_DATA_WIDTH);
  localparam int W_DEPTH        = DEF_R_DEPTH / RATIO;
  localparam int PLANNED_CYCLES = 300;  // Sum of all test lengths, rounded up.
  localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        clken;
  logic        w_en;
  logic        r_en;
  logic [31:0] s_data;
  logic [3:0]  r_addr_max;
  logic [3:0]  r_addr_min;
  logic [1:0]  w_addr_max;
  logic [7:0]  m_data;
  logic        m_valid;

  logic [31:0] shadow [W_DEPTH];  // Mirror of the wide words written.
  logic [7:0]  exp_q [$];
  logic [31:0] rng;
  int          rd_ptr;
  int          wr_ptr;
  int          errors;
  int          checks;
  int          tests;
  int          test_errors;
  int          cycles;
  logic [7:0]  last_data;
  logic        last_valid;
  logic        last_ck;
  logic        last_rst;

  weight_buffer_top #(.ABSORB(1'b1)) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (s_data),
    .r_addr_max (r_addr_max),
    .r_addr_min (r_addr_min),
    .w_addr_max (w_addr_max),
    .m_data     (m_data),
    .m_valid    (m_valid)
  );

  bind cyclic_bram tb_sva #(
    .R_AW  (R_ADDR_WIDTH),
    .W_AW  (W_ADDR_WIDTH),
    .DEPTH (FIFO_DEPTH)
  ) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .r_en       (r_en),
    .r_addr     (r_addr),
    .r_addr_max (r_addr_max),
    .w_addr     (w_addr),
    .w_addr_max (w_addr_max),
    .push       (rd_valid),
    .m_valid    (m_valid)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Narrow word k of wide address a sits at a*RATIO+k, slice 0 lowest.
  function automatic logic [7:0] ref_word(input int addr);
    logic [31:0] wide;
    wide = shadow[addr / RATIO];
    return wide[(addr % RATIO)*8 +: 8];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One clock of stimulus; the model sees the same edge as the DUT.
  task automatic step(input logic ck, input logic w, input logic r, input logic [31:0] d);
    @(posedge clk);
    #2;
    clken  = ck;
    w_en   = w;
    r_en   = r;
    s_data = d;
    if (ck && r) begin
      exp_q.push_back(ref_word(rd_ptr));  // Read sees memory before this edge's write.
      rd_ptr = (rd_ptr == int'(r_addr_max)) ? int'(r_addr_min) : rd_ptr + 1;
    end
    if (ck && w) begin
      shadow[wr_ptr] = d;
      wr_ptr = (wr_ptr == int'(w_addr_max)) ? 0 : wr_ptr + 1;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d (%s) done with %0d errors", tests, name, errors - test_errors);
    test_errors = errors;
  endtask

  // Each enabled edge consumes the m_valid seen at the negedge before it.
  always @(negedge clk) begin
    if (rst_n && clken && m_valid) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t ns: m_valid high with no read outstanding", $time);
        errors++;
      end else begin
        check_value("m_data", m_data, exp_q.pop_front());
      end
    end
    if (!last_ck && last_rst && rst_n) begin
      check_value("m_data", m_data, last_data);  // Stalled edge changes nothing.
      check_value("m_valid", m_valid, last_valid);
    end
    last_data  = m_data;
    last_valid = m_valid;
    last_ck    = clken;
    last_rst   = rst_n;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int writes_done;
    logic ck;
    logic w;
    clk = 1'b0;
    rst_n = 1'b0;
    clken = 1'b1;
    w_en = 1'b0;
    r_en = 1'b0;
    s_data = '0;
    r_addr_max = 4'd15;
    r_addr_min = 4'd0;
    w_addr_max = 2'd3;
    rng = 32'hc63b;
    rd_ptr = 0;
    wr_ptr = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    test_errors = 0;
    cycles = 0;
    last_ck = 1'b1;
    last_rst = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;

    for (int i = 0; i < W_DEPTH; i++) step(1'b1, 1'b1, 1'b0, next_rand());
    for (int i = 0; i < 16; i++) step(1'b1, 1'b0, 1'b1, '0);
    end_test("full window");

    // The last read still has to meet the old window on its edge.
    step(1'b1, 1'b0, 1'b0, '0);
    r_addr_min = 4'd4;
    r_addr_max = 4'd11;
    for (int i = 0; i < 28; i++) step(1'b1, 1'b0, 1'b1, '0);
    end_test("narrow window laps");

    for (int i = 0; i < 60; i++) step(1'b1, 1'b0, next_rand() % 3 != 0, '0);
    end_test("random r_en gaps");

    writes_done = 0;
    for (int i = 0; i < 80; i++) begin
      ck = (next_rand() % 3) != 0;
      w = (writes_done < W_DEPTH) && next_rand() % 4 == 0;
      step(ck, w, 1'b1, next_rand());
      if (ck && w) writes_done++;
    end
    while (writes_done < W_DEPTH) begin
      step(1'b1, 1'b1, 1'b0, next_rand());
      writes_done++;
    end
    end_test("clken stalls");

    step(1'b1, 1'b0, 1'b0, '0);
    w_addr_max = 2'd1;
    r_addr_min = 4'd0;
    r_addr_max = 4'd15;
    for (int i = 0; i < 5; i++) step(1'b1, 1'b1, 1'b0, next_rand());
    for (int i = 0; i < 24; i++) step(1'b1, 1'b0, 1'b1, '0);
    end_test("rewrite with write wrap");

    for (int i = 0; i < 10; i++) step(1'b1, 1'b0, 1'b1, '0);
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    clken = 1'b1;
    w_en = 1'b0;
    r_en = 1'b0;
    exp_q.delete();  // Words in flight are dropped by the reset.
    rd_ptr = 0;
    wr_ptr = 0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    check_value("m_valid", m_valid, 1'b0);
    for (int i = 0; i < 24; i++) step(1'b1, 1'b0, 1'b1, '0);
    end_test("reset mid-stream");

    @(posedge clk);
    #2 r_en = 1'b0;
    @(negedge clk);
    #1;
    // After a long unbroken stream one word waits in the FIFO and LATENCY more are in the pipeline.
    check_value("outstanding reads", exp_q.size(), DEF_LATENCY + 1);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
src/cyc_pkg.sv
src/ram_port_if.sv
src/n_delay.sv
src/sdp_ram.sv
src/sync_fifo.sv
src/cyclic_bram.sv
src/weight_buffer_top.sv
testbench/tb_sva.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f list.f -o sim_top

./obj_dir/sim_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
